// File: src/ciPkg.sv
`default_nettype none

package ciPkg;

  //////////////////////////////////////////////////////////////////////
  // Custom-instruction data types
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] ciWord;  // Operand or result word
  typedef logic [7:0]  ciId;    // Instruction number on ciN

  //////////////////////////////////////////////////////////////////////
  // Default instruction numbers
  //////////////////////////////////////////////////////////////////////

  localparam ciId idSwapByte  = 8'd1;
  localparam ciId idDelay     = 8'd6;
  localparam ciId idProfiler  = 8'd11;  // 0x0B
  localparam ciId idGrayscale = 8'd12;  // 0x0C

endpackage

`default_nettype wire

// File: src/sysPkg.sv
`default_nettype none

package sysPkg;

  typedef logic [4:0]  resetCount;  // Top bit marks the end of reset
  typedef logic [31:0] eventCount;
  typedef logic [1:0]  counterSel;

  // Profiler counter selection on dataA[1:0]
  localparam counterSel selCycles  = 2'd0;
  localparam counterSel selStall   = 2'd1;
  localparam counterSel selBusIdle = 2'd2;

endpackage

`default_nettype wire

// File: src/ciIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ciIf;
  import ciPkg::*;

  logic  start;  // One-cycle pulse per instruction
  ciId   n;
  ciWord dataA;
  ciWord dataB;

  modport issuer (
    output start,
    output n,
    output dataA,
    output dataB
  );

  modport unit (
    input start,
    input n,
    input dataA,
    input dataB
  );

endinterface

`default_nettype wire

// File: src/resetSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReady,
  output logic unitReset
);
  import sysPkg::*;

  localparam int topBit = $bits(resetCount) - 1;

  resetCount lockCount;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      lockCount <= '0;
    end else if (!lockCount[topBit]) begin
      lockCount <= lockCount + 5'd1;  // Freezes once the top bit sets
    end
  end

  assign systemReady = lockCount[topBit];
  assign unitReset   = ~lockCount[topBit];

  // Counting is monotonic for as long as the clock stays locked
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    $past(s_pllLocked) |-> lockCount >= $past(lockCount));

endmodule

`default_nettype wire

// File: src/swapByteUnit.sv
`timescale 1ns/1ps
`default_nettype none

module swapByteUnit #(
  parameter ciPkg::ciId customId = ciPkg::idSwapByte
) (
  input  logic         s_systemClock,
  input  logic         unitReset,
  ciIf.unit            ci,
  output logic         done,
  output ciPkg::ciWord result
);
  import ciPkg::*;

  logic  match;
  ciWord swapped;

  assign match = ci.start && (ci.n == customId);

  always_comb begin
    if (ci.dataB[0]) begin
      swapped = {ci.dataA[23:16], ci.dataA[31:24], ci.dataA[7:0], ci.dataA[15:8]};  // Per half
    end else begin
      swapped = {ci.dataA[7:0], ci.dataA[15:8], ci.dataA[23:16], ci.dataA[31:24]};  // Full word
    end
  end

  assign done   = match;
  assign result = match ? swapped : '0;

  assert property (@(posedge s_systemClock) disable iff (unitReset)
    done |-> ci.start);

endmodule

`default_nettype wire

// File: src/grayscaleUnit.sv
`timescale 1ns/1ps
`default_nettype none

module grayscaleUnit #(
  parameter ciPkg::ciId customId = ciPkg::idGrayscale
) (
  input  logic         s_systemClock,
  input  logic         unitReset,
  ciIf.unit            ci,
  output logic         done,
  output ciPkg::ciWord result
);
  import ciPkg::*;

  logic        match;
  logic [7:0]  red8;
  logic [7:0]  green8;
  logic [7:0]  blue8;
  logic [15:0] graySum;

  assign match = ci.start && (ci.n == customId);

  // RGB565 channels widened by replicating their top bits
  assign red8   = {ci.dataA[15:11], ci.dataA[15:13]};
  assign green8 = {ci.dataA[10:5], ci.dataA[10:9]};
  assign blue8  = {ci.dataA[4:0], ci.dataA[4:2]};

  // Weights add up to 256 so the sum fits in 16 bits
  assign graySum = 16'd54 * red8 + 16'd183 * green8 + 16'd19 * blue8;

  assign done   = match;
  assign result = match ? {24'd0, graySum[15:8]} : '0;

  // Equal channels map to the same gray level
  assert property (@(posedge s_systemClock) disable iff (unitReset)
    done && (red8 == green8) && (green8 == blue8) |-> (result[7:0] == red8));

endmodule

`default_nettype wire

// File: src/delayUnit.sv
`timescale 1ns/1ps
`default_nettype none

module delayUnit #(
  parameter ciPkg::ciId customId             = ciPkg::idDelay,
  parameter int         cyclesPerMicrosecond = 4
) (
  input  logic         s_systemClock,
  input  logic         unitReset,
  ciIf.unit            ci,
  output logic         done,
  output ciPkg::ciWord result
);
  import ciPkg::*;

  typedef enum logic {
    idle,
    counting
  } delayState;

  delayState state;
  ciWord     remaining;
  ciWord     loadValue;
  logic      match;

  assign match     = ci.start && (ci.n == customId);
  assign loadValue = ci.dataA * ciWord'(cyclesPerMicrosecond);  // Load edge adds one

  always_ff @(posedge s_systemClock or posedge unitReset) begin
    if (unitReset) begin
      state     <= idle;
      remaining <= '0;
    end else begin
      case (state)
        idle: begin
          if (match) begin
            state     <= counting;
            remaining <= loadValue;
          end
        end
        counting: begin
          if (remaining == '0) begin
            state <= idle;  // Done cycle ends here
          end else begin
            remaining <= remaining - 32'd1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  assign done   = (state == counting) && (remaining == '0);
  assign result = '0;

  assert property (@(posedge s_systemClock) disable iff (unitReset)
    done |-> (state == counting) ##1 (state == idle));

  // The processor blocks until done, so no new instruction overlaps a delay
  assert property (@(posedge s_systemClock) disable iff (unitReset)
    ci.start |-> (state == idle));

endmodule

`default_nettype wire

// File: src/profilerUnit.sv
`timescale 1ns/1ps
`default_nettype none

module profilerUnit #(
  parameter ciPkg::ciId customId = ciPkg::idProfiler
) (
  input  logic         s_systemClock,
  input  logic         unitReset,
  input  logic         stall,
  input  logic         busIdle,
  ciIf.unit            ci,
  output logic         done,
  output ciPkg::ciWord result
);
  import sysPkg::*;

  logic      match;
  logic      countEnable;
  counterSel readSel;
  eventCount cycleCounter;
  eventCount stallCounter;
  eventCount idleCounter;
  eventCount readValue;

  assign match   = ci.start && (ci.n == customId);
  assign readSel = ci.dataA[1:0];

  always_comb begin
    case (readSel)
      selCycles:  readValue = cycleCounter;
      selStall:   readValue = stallCounter;
      selBusIdle: readValue = idleCounter;
      default:    readValue = '0;
    endcase
  end

  assign done   = match;
  assign result = match ? readValue : '0;  // Value before this cycle's update

  //////////////////////////////////////////////////////////////////////
  // Control and event counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge s_systemClock or posedge unitReset) begin
    if (unitReset) begin
      countEnable  <= 1'b0;
      cycleCounter <= '0;
      stallCounter <= '0;
      idleCounter  <= '0;
    end else begin
      if (match && ci.dataB[0]) countEnable <= 1'b1;
      else if (match && ci.dataB[1]) countEnable <= 1'b0;

      if (match && ci.dataB[2]) begin  // Clear wins over counting
        cycleCounter <= '0;
        stallCounter <= '0;
        idleCounter  <= '0;
      end else if (countEnable) begin
        cycleCounter <= cycleCounter + 32'd1;
        if (stall) stallCounter <= stallCounter + 32'd1;
        if (busIdle) idleCounter <= idleCounter + 32'd1;
      end
    end
  end

  assert property (@(posedge s_systemClock) disable iff (unitReset)
    match |-> !(ci.dataB[0] && ci.dataB[1]));

endmodule

`default_nettype wire

// File: src/ciCluster.sv
`timescale 1ns/1ps
`default_nettype none

module ciCluster #(
  parameter int cyclesPerMicrosecond = 4
) (
  input  logic         s_systemClock,
  input  logic         s_pllLocked,
  input  logic         stall,
  input  logic         busIdle,
  input  logic         ciStart,
  input  ciPkg::ciId   ciN,
  input  ciPkg::ciWord ciDataA,
  input  ciPkg::ciWord ciDataB,
  output logic         ciDone,
  output ciPkg::ciWord ciResult,
  output logic         systemReady
);
  import ciPkg::*;

  logic  unitReset;
  logic  swapDone, grayDone, delayDone, profDone;
  ciWord swapResult, grayResult, delayResult, profResult;

  ciIf ciBus ();

  resetSequencer i_resetSequencer (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .systemReady  (systemReady),
    .unitReset    (unitReset)
  );

  //////////////////////////////////////////////////////////////////////
  // Shared instruction bus
  //////////////////////////////////////////////////////////////////////

  assign ciBus.start = ciStart & systemReady;  // No issue before ready
  assign ciBus.n     = ciN;
  assign ciBus.dataA = ciDataA;
  assign ciBus.dataB = ciDataB;

  swapByteUnit #(.customId(idSwapByte)) i_swapByteUnit (
    .s_systemClock(s_systemClock), .unitReset(unitReset), .ci(ciBus),
    .done(swapDone), .result(swapResult)
  );

  grayscaleUnit #(.customId(idGrayscale)) i_grayscaleUnit (
    .s_systemClock(s_systemClock), .unitReset(unitReset), .ci(ciBus),
    .done(grayDone), .result(grayResult)
  );

  delayUnit #(
    .customId            (idDelay),
    .cyclesPerMicrosecond(cyclesPerMicrosecond)
  ) i_delayUnit (
    .s_systemClock(s_systemClock), .unitReset(unitReset), .ci(ciBus),
    .done(delayDone), .result(delayResult)
  );

  profilerUnit #(.customId(idProfiler)) i_profilerUnit (
    .s_systemClock(s_systemClock), .unitReset(unitReset),
    .stall(stall), .busIdle(busIdle), .ci(ciBus),
    .done(profDone), .result(profResult)
  );

  // Idle units drive zeros
  assign ciDone   = swapDone | grayDone | delayDone | profDone;
  assign ciResult = swapResult | grayResult | delayResult | profResult;

endmodule

`default_nettype wire

// File: sim/ciClusterTb.sv
`timescale 1ns/1ps
`default_nettype none

module ciClusterTb;
  import ciPkg::*;
  import sysPkg::*;

  localparam int clockPeriod = 4;
  localparam int cyclesPerUs = 4;
  localparam int maxRows     = 32;
  localparam int waitLimit   = 2000;  // Cycles per instruction

  logic        s_systemClock;
  logic        s_pllLocked;
  logic        stall;
  logic        busIdle;
  logic        ciStart;
  ciId         ciN;
  ciWord       ciDataA;
  ciWord       ciDataB;
  logic        ciDone;
  ciWord       ciResult;
  logic        systemReady;
  ciWord       goldenMem [0:maxRows*5-1];
  int          errorCount;
  int          testCount;
  int          failedTests;

  ciCluster #(.cyclesPerMicrosecond(cyclesPerUs)) i_ciCluster (
    .s_systemClock(s_systemClock), .s_pllLocked(s_pllLocked),
    .stall(stall), .busIdle(busIdle), .ciStart(ciStart), .ciN(ciN),
    .ciDataA(ciDataA), .ciDataB(ciDataB), .ciDone(ciDone),
    .ciResult(ciResult), .systemReady(systemReady)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #(clockPeriod / 2) s_systemClock = ~s_systemClock;
  end

  //////////////////////////////////////////////////////////////////////
  // Compare and bookkeeping
  //////////////////////////////////////////////////////////////////////

  task automatic checkWord(input string name, input ciWord got, input ciWord expected);
    if (got !== expected) begin
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, expected);
      errorCount++;
    end
  endtask

  task automatic checkCount(input string name, input eventCount got,
                            input eventCount expected);
    if (got !== expected) begin
      $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, expected);
      errorCount++;
    end
  endtask

  task automatic endTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore) begin
      $display("test %s: passed", name);
    end else begin
      failedTests++;
      $display("test %s: failed", name);
    end
  endtask

  // One instruction; edges counts rising edges from the start edge to ciDone
  task automatic issue(input ciId id, input ciWord a, input ciWord b,
                       output eventCount edges, output ciWord res, output logic seen);
    edges = '0;
    res   = '0;
    seen  = 1'b0;
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN     <= id;
    ciDataA <= a;
    ciDataB <= b;
    while (!seen && edges < waitLimit) begin
      @(negedge s_systemClock);
      if (ciDone) begin
        seen = 1'b1;
        res  = ciResult;
      end else begin
        @(posedge s_systemClock);
        ciStart <= 1'b0;
        edges++;
      end
    end
    @(posedge s_systemClock);
    ciStart <= 1'b0;
    if (!seen) begin
      $display("Timeout: instruction %0d gave no ciDone within %0d cycles", id, waitLimit);
      errorCount++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic checkReset();
    int        errorsBefore;
    eventCount edges;
    logic      ready;
    errorsBefore = errorCount;
    edges        = '0;
    ready        = 1'b0;
    @(negedge s_systemClock);
    checkWord("systemReady", ciWord'(systemReady), '0);
    checkWord("ciDone", ciWord'(ciDone), '0);
    @(posedge s_systemClock);
    ciStart <= 1'b1;  // Swap request that must stay unanswered
    ciN     <= idSwapByte;
    ciDataA <= 32'h12345678;
    @(negedge s_systemClock);
    checkWord("systemReady", ciWord'(systemReady), '0);
    checkWord("ciDone", ciWord'(ciDone), '0);
    checkWord("ciResult", ciResult, '0);
    @(posedge s_systemClock);
    s_pllLocked <= 1'b1;
    ciStart     <= 1'b0;
    while (!ready && edges < 64) begin
      @(negedge s_systemClock);
      if (systemReady) begin
        ready = 1'b1;
      end else begin
        checkWord("ciDone", ciWord'(ciDone), '0);
        @(posedge s_systemClock);
        edges++;
      end
    end
    if (!ready) begin
      $display("Timeout: systemReady never rose after the lock was released");
      errorCount++;
    end
    checkCount("systemReady edges after lock", edges, 32'd16);
    endTest("reset sequence", errorsBefore);
  endtask

  task automatic runGolden();
    int        row;
    int        errorsBefore;
    ciWord     kind;
    eventCount edges;
    ciWord     res;
    logic      seen;
    string     label;
    row = 0;
    $readmemh("sim/ciGolden.txt", goldenMem);
    while (row < maxRows && goldenMem[row*5] >= 32'd1 && goldenMem[row*5] <= 32'd3) begin
      errorsBefore = errorCount;
      kind         = goldenMem[row*5];
      label        = $sformatf("golden row %0d kind %0d", row, kind);
      issue(ciId'(goldenMem[row*5+1]), goldenMem[row*5+2], goldenMem[row*5+3],
            edges, res, seen);
      if (kind == 32'd3) begin  // Delay
        checkCount({label, " ciDone edges"}, edges, goldenMem[row*5+4]);
        checkWord({label, " ciResult"}, res, '0);
      end else begin
        checkCount({label, " ciDone edges"}, edges, '0);
        checkWord({label, " ciResult"}, res, goldenMem[row*5+4]);
      end
      endTest(label, errorsBefore);
      row++;
    end
    if (row == 0) begin
      $display("The golden file held no vectors");
      errorCount++;
    end
  endtask

  task automatic runProfiler();
    int          errorsBefore;
    int          runCycles;
    int          i;
    logic [31:0] randomBits;
    eventCount   expCycles;
    eventCount   expStall;
    eventCount   expIdle;
    eventCount   edges;
    ciWord       res;
    logic        seen;
    errorsBefore = errorCount;
    expStall     = '0;
    expIdle      = '0;
    runCycles    = 20 + int'($urandom % 40);
    issue(idProfiler, 32'd0, 32'h5, edges, res, seen);  // Clear and enable
    for (i = 0; i < runCycles; i++) begin
      randomBits = $urandom;
      stall   <= randomBits[0];
      busIdle <= randomBits[1];
      expStall = expStall + {31'd0, randomBits[0]};
      expIdle  = expIdle + {31'd0, randomBits[1]};
      @(posedge s_systemClock);
    end
    stall   <= 1'b0;
    busIdle <= 1'b0;
    // Two more enabled edges: the issue edge and the disable edge itself
    expCycles = eventCount'(runCycles) + 32'd2;
    issue(idProfiler, 32'd0, 32'h2, edges, res, seen);
    issue(idProfiler, {30'd0, selCycles}, '0, edges, res, seen);
    checkCount("profiler cycle counter", res, expCycles);
    issue(idProfiler, {30'd0, selStall}, '0, edges, res, seen);
    checkCount("profiler stall counter", res, expStall);
    issue(idProfiler, {30'd0, selBusIdle}, '0, edges, res, seen);
    checkCount("profiler bus-idle counter", res, expIdle);
    issue(idProfiler, 32'd3, '0, edges, res, seen);
    checkWord("profiler select 3 ciResult", res, '0);
    endTest("profiler counters", errorsBefore);
  endtask

  task automatic runUnusedId();
    int errorsBefore;
    int cycle;
    errorsBefore = errorCount;
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN     <= 8'd9;
    ciDataA <= 32'hFFFFFFFF;
    ciDataB <= 32'h00000004;
    for (cycle = 0; cycle < 50; cycle++) begin
      @(negedge s_systemClock);
      checkWord("ciDone", ciWord'(ciDone), '0);
      checkWord("ciResult", ciResult, '0);
      @(posedge s_systemClock);
      ciStart <= 1'b0;
    end
    endTest("unused id 9", errorsBefore);
  endtask

  initial begin
    void'($urandom(35094));
    errorCount  = 0;
    testCount   = 0;
    failedTests = 0;
    s_pllLocked = 1'b0;
    stall       = 1'b0;
    busIdle     = 1'b0;
    ciStart     = 1'b0;
    ciN         = '0;
    ciDataA     = '0;
    ciDataB     = '0;
    checkReset();
    runGolden();
    runProfiler();
    runUnusedId();
    $display("%0d tests run, %0d failed, %0d check errors", testCount, failedTests,
             errorCount);
    if (errorCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
src/ciPkg.sv
src/sysPkg.sv
src/ciIf.sv
src/resetSequencer.sv
src/swapByteUnit.sv
src/grayscaleUnit.sv
src/delayUnit.sv
src/profilerUnit.sv
src/ciCluster.sv
sim/ciClusterTb.sv

// File: Makefile
# Verilator simulation of the custom-instruction cluster

VERILATOR ?= verilator
TOP       ?= ciClusterTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/ciGolden.txt
// Columns (hex): kind ciN dataA dataB expected
// Kind 1 swap byte, 2 grayscale, 3 delay where expected is the ciDone edge count
1 01 12345678 00000000 78563412
1 01 12345678 00000001 34127856
1 01 DEADBEEF 00000000 EFBEADDE
1 01 DEADBEEF 00000001 ADDEEFBE
1 01 000000FF 00000000 FF000000
1 01 A5C30F01 00000001 C3A5010F
2 0C 0000F800 00000000 00000035
2 0C 000007E0 00000000 000000B6
2 0C 0000001F 00000000 00000012
2 0C 0000FFFF 00000000 000000FF
2 0C 00000000 00000000 00000000
2 0C 00008410 00000000 00000082
2 0C FFFF0000 00000000 00000000
3 06 00000000 00000000 00000001
3 06 00000001 00000000 00000005
3 06 00000003 00000000 0000000D
3 06 0000000A 00000000 00000029
0 00 00000000 00000000 00000000
